//--- Makefile
# Verilator build for the RISC-V decoder; any variable can be set on the command line

VERILATOR ?= verilator
TOP       ?= decoder_tb
FILELIST  ?= rv_decoder.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST)) $(wildcard tests/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- design/decode_ctrl.sv
// control decode: opcode and function fields into ALU, LSU, mul/div, CSR and event controls
`timescale 1ns/1ns

module decode_ctrl #(
  parameter bit RV32M = 1'b1  // accept mul/div encodings
) (
  input  logic [decoder_pkg::XLEN-1:0] instr_i,
  output decoder_pkg::dec_ctrl_t       ctrl_o
);

  decoder_pkg::opcode_e               opcode;
  logic [2:0]                         funct3;
  logic [6:0]                         funct7;
  logic [11:0]                        imm12;  // system code or csr address
  logic [decoder_pkg::REG_ADDR_W-1:0] rs1;
  logic [decoder_pkg::REG_ADDR_W-1:0] rd;

  assign opcode = decoder_pkg::opcode_e'(instr_i[6:0]);
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];
  assign imm12  = instr_i[31:20];
  assign rs1    = instr_i[19:15];
  assign rd     = instr_i[11:7];

  always_comb begin
    // defaults: nothing happens, encoding legal
    ctrl_o.alu_op         = decoder_pkg::ALU_SLTU;
    ctrl_o.op_a_sel       = decoder_pkg::OP_A_IMM;
    ctrl_o.op_b_sel       = decoder_pkg::OP_B_IMM;
    ctrl_o.imm_a_sel      = decoder_pkg::IMM_A_ZERO;
    ctrl_o.imm_b_sel      = decoder_pkg::IMM_B_I;
    ctrl_o.rf_we          = 1'b0;
    ctrl_o.rf_wd_sel      = decoder_pkg::RF_WD_EX;
    ctrl_o.data_req       = 1'b0;
    ctrl_o.data_we        = 1'b0;
    ctrl_o.data_size      = decoder_pkg::MEM_WORD;
    ctrl_o.data_sign_ext  = 1'b0;
    ctrl_o.mult_en        = 1'b0;
    ctrl_o.div_en         = 1'b0;
    ctrl_o.md_op          = decoder_pkg::MD_OP_MULL;
    ctrl_o.md_signed_mode = 2'b00;
    ctrl_o.csr_access     = 1'b0;
    ctrl_o.csr_op         = decoder_pkg::CSR_OP_READ;
    ctrl_o.csr_status     = 1'b0;
    ctrl_o.jump           = 1'b0;
    ctrl_o.branch         = 1'b0;
    ctrl_o.ecall          = 1'b0;
    ctrl_o.ebrk           = 1'b0;
    ctrl_o.mret           = 1'b0;
    ctrl_o.wfi            = 1'b0;
    ctrl_o.illegal        = 1'b0;

    unique case (opcode)
      ////////////////////////////////////////
      // jumps and branches, target only
      ////////////////////////////////////////
      decoder_pkg::OPC_JAL: begin
        ctrl_o.jump      = 1'b1;
        ctrl_o.op_a_sel  = decoder_pkg::OP_A_CURRPC;  // pc + imm_j
        ctrl_o.imm_b_sel = decoder_pkg::IMM_B_J;
        ctrl_o.alu_op    = decoder_pkg::ALU_ADD;
      end
      decoder_pkg::OPC_JALR: begin
        ctrl_o.jump      = 1'b1;
        ctrl_o.op_a_sel  = decoder_pkg::OP_A_REG_A;   // rs1 + imm_i
        ctrl_o.alu_op    = decoder_pkg::ALU_ADD;
        ctrl_o.illegal   = (funct3 != 3'b000);
      end
      decoder_pkg::OPC_BRANCH: begin
        ctrl_o.branch    = 1'b1;
        ctrl_o.op_a_sel  = decoder_pkg::OP_A_REG_A;   // compare rs1 with rs2
        ctrl_o.op_b_sel  = decoder_pkg::OP_B_REG_B;
        ctrl_o.imm_b_sel = decoder_pkg::IMM_B_B;      // offset for target adder
        unique case (funct3)
          3'b000:  ctrl_o.alu_op = decoder_pkg::ALU_EQ;
          3'b001:  ctrl_o.alu_op = decoder_pkg::ALU_NE;
          3'b100:  ctrl_o.alu_op = decoder_pkg::ALU_LT;
          3'b101:  ctrl_o.alu_op = decoder_pkg::ALU_GE;
          3'b110:  ctrl_o.alu_op = decoder_pkg::ALU_LTU;
          3'b111:  ctrl_o.alu_op = decoder_pkg::ALU_GEU;
          default: ctrl_o.illegal = 1'b1;             // 010, 011
        endcase
      end
      ////////////////////////////////////////
      // loads and stores
      ////////////////////////////////////////
      decoder_pkg::OPC_LOAD, decoder_pkg::OPC_STORE: begin
        ctrl_o.data_req = 1'b1;
        ctrl_o.op_a_sel = decoder_pkg::OP_A_REG_A;    // address = rs1 + offset
        ctrl_o.alu_op   = decoder_pkg::ALU_ADD;
        unique case (funct3[1:0])
          2'b00:   ctrl_o.data_size = decoder_pkg::MEM_BYTE;
          2'b01:   ctrl_o.data_size = decoder_pkg::MEM_HALF;
          2'b10:   ctrl_o.data_size = decoder_pkg::MEM_WORD;
          default: ctrl_o.illegal   = 1'b1;           // 64 bit, rv64 only
        endcase
        if (opcode == decoder_pkg::OPC_STORE) begin
          ctrl_o.data_we   = 1'b1;
          ctrl_o.imm_b_sel = decoder_pkg::IMM_B_S;
          if (funct3[2]) ctrl_o.illegal = 1'b1;       // no register offset store
        end else begin
          ctrl_o.rf_we         = 1'b1;
          ctrl_o.rf_wd_sel     = decoder_pkg::RF_WD_LSU;
          ctrl_o.data_sign_ext = ~funct3[2];          // lbu/lhu zero extend
          if (funct3 == 3'b110) ctrl_o.illegal = 1'b1;  // lwu
        end
      end
      ////////////////////////////////////////
      // alu
      ////////////////////////////////////////
      decoder_pkg::OPC_LUI, decoder_pkg::OPC_AUIPC: begin
        ctrl_o.imm_b_sel = decoder_pkg::IMM_B_U;
        ctrl_o.alu_op    = decoder_pkg::ALU_ADD;
        ctrl_o.rf_we     = 1'b1;
        if (opcode == decoder_pkg::OPC_AUIPC) ctrl_o.op_a_sel = decoder_pkg::OP_A_CURRPC;
      end
      decoder_pkg::OPC_OP_IMM: begin
        ctrl_o.op_a_sel = decoder_pkg::OP_A_REG_A;
        ctrl_o.rf_we    = 1'b1;
        unique case (funct3)
          3'b000: ctrl_o.alu_op = decoder_pkg::ALU_ADD;
          3'b010: ctrl_o.alu_op = decoder_pkg::ALU_SLT;
          3'b011: ctrl_o.alu_op = decoder_pkg::ALU_SLTU;
          3'b100: ctrl_o.alu_op = decoder_pkg::ALU_XOR;
          3'b110: ctrl_o.alu_op = decoder_pkg::ALU_OR;
          3'b111: ctrl_o.alu_op = decoder_pkg::ALU_AND;
          3'b001: begin
            ctrl_o.alu_op  = decoder_pkg::ALU_SLL;
            ctrl_o.illegal = (funct7 != 7'b000_0000);
          end
          default: begin  // 101, srli or srai
            ctrl_o.alu_op  = funct7[5] ? decoder_pkg::ALU_SRA : decoder_pkg::ALU_SRL;
            ctrl_o.illegal = ((funct7 & 7'b101_1111) != 7'b000_0000);
          end
        endcase
      end
      decoder_pkg::OPC_OP: begin
        ctrl_o.op_a_sel = decoder_pkg::OP_A_REG_A;
        ctrl_o.op_b_sel = decoder_pkg::OP_B_REG_B;
        ctrl_o.rf_we    = 1'b1;
        if (funct7 == 7'b000_0001) begin  // rv32m
          ctrl_o.alu_op  = decoder_pkg::ALU_ADD;
          ctrl_o.mult_en = RV32M & ~funct3[2];
          ctrl_o.div_en  = RV32M & funct3[2];
          ctrl_o.illegal = !RV32M;
          unique case (funct3)
            3'b000:                ctrl_o.md_op = decoder_pkg::MD_OP_MULL;
            3'b001, 3'b010, 3'b011: ctrl_o.md_op = decoder_pkg::MD_OP_MULH;
            3'b100, 3'b101:        ctrl_o.md_op = decoder_pkg::MD_OP_DIV;
            default:               ctrl_o.md_op = decoder_pkg::MD_OP_REM;
          endcase
          unique case (funct3)
            3'b001, 3'b100, 3'b110: ctrl_o.md_signed_mode = 2'b11;  // mulh, div, rem
            3'b010:                 ctrl_o.md_signed_mode = 2'b01;  // mulhsu
            default:                ctrl_o.md_signed_mode = 2'b00;
          endcase
        end else begin
          unique case ({funct7, funct3})
            {7'b000_0000, 3'b000}: ctrl_o.alu_op = decoder_pkg::ALU_ADD;
            {7'b010_0000, 3'b000}: ctrl_o.alu_op = decoder_pkg::ALU_SUB;
            {7'b000_0000, 3'b001}: ctrl_o.alu_op = decoder_pkg::ALU_SLL;
            {7'b000_0000, 3'b010}: ctrl_o.alu_op = decoder_pkg::ALU_SLT;
            {7'b000_0000, 3'b011}: ctrl_o.alu_op = decoder_pkg::ALU_SLTU;
            {7'b000_0000, 3'b100}: ctrl_o.alu_op = decoder_pkg::ALU_XOR;
            {7'b000_0000, 3'b101}: ctrl_o.alu_op = decoder_pkg::ALU_SRL;
            {7'b010_0000, 3'b101}: ctrl_o.alu_op = decoder_pkg::ALU_SRA;
            {7'b000_0000, 3'b110}: ctrl_o.alu_op = decoder_pkg::ALU_OR;
            {7'b000_0000, 3'b111}: ctrl_o.alu_op = decoder_pkg::ALU_AND;
            default:               ctrl_o.illegal = 1'b1;
          endcase
        end
      end
      ////////////////////////////////////////
      // fence and system
      ////////////////////////////////////////
      decoder_pkg::OPC_MISC_MEM: begin
        ctrl_o.op_a_sel = decoder_pkg::OP_A_REG_A;  // fence is a nop add
        ctrl_o.alu_op   = decoder_pkg::ALU_ADD;
        ctrl_o.illegal  = (funct3 != 3'b000);       // fence.i not supported
      end
      decoder_pkg::OPC_SYSTEM: begin
        if (funct3 == 3'b000) begin
          ctrl_o.op_a_sel = decoder_pkg::OP_A_REG_A;
          unique case (imm12)
            12'h000: ctrl_o.ecall   = 1'b1;
            12'h001: ctrl_o.ebrk    = 1'b1;
            12'h302: ctrl_o.mret    = 1'b1;
            12'h105: ctrl_o.wfi     = 1'b1;
            default: ctrl_o.illegal = 1'b1;
          endcase
          if (rs1 != '0 || rd != '0) ctrl_o.illegal = 1'b1;  // both fields must be x0
        end else begin
          ctrl_o.csr_access = 1'b1;
          ctrl_o.rf_we      = 1'b1;
          ctrl_o.rf_wd_sel  = decoder_pkg::RF_WD_CSR;
          ctrl_o.imm_a_sel  = decoder_pkg::IMM_A_Z;
          ctrl_o.op_a_sel   = funct3[2] ? decoder_pkg::OP_A_IMM : decoder_pkg::OP_A_REG_A;
          unique case (funct3[1:0])
            2'b01:   ctrl_o.csr_op  = decoder_pkg::CSR_OP_WRITE;
            2'b10:   ctrl_o.csr_op  = decoder_pkg::CSR_OP_SET;
            2'b11:   ctrl_o.csr_op  = decoder_pkg::CSR_OP_CLEAR;
            default: ctrl_o.illegal = 1'b1;
          endcase
          // flush on mstatus and debug csrs
          ctrl_o.csr_status = !ctrl_o.illegal &&
                              (imm12 inside {decoder_pkg::CSR_MSTATUS, decoder_pkg::CSR_DCSR,
                                             decoder_pkg::CSR_DPC, decoder_pkg::CSR_DSCRATCH0,
                                             decoder_pkg::CSR_DSCRATCH1});
        end
      end
      default: ctrl_o.illegal = 1'b1;  // unknown opcode
    endcase
  end

endmodule

//--- design/decode_fields.sv
// field extraction: register addresses and extended immediates from one instruction word
`timescale 1ns/1ns

module decode_fields (
  input  logic [decoder_pkg::XLEN-1:0] instr_i,
  output decoder_pkg::dec_fields_t     fields_o
);

  logic sign;  // instr bit 31, sign of every immediate

  assign sign = instr_i[31];

  ////////////////////////////////////////
  // register addresses
  ////////////////////////////////////////

  assign fields_o.rs1 = instr_i[19:15];
  assign fields_o.rs2 = instr_i[24:20];
  assign fields_o.rd  = instr_i[11:7];

  ////////////////////////////////////////
  // immediates
  ////////////////////////////////////////

  // I: loads, op-imm, jalr, csr address
  assign fields_o.imm_i = {{20{sign}}, instr_i[31:20]};
  // S: store offset split around rd
  assign fields_o.imm_s = {{20{sign}}, instr_i[31:25], instr_i[11:7]};
  // B: branch offset, bit 0 always zero
  assign fields_o.imm_b = {{19{sign}}, sign, instr_i[7], instr_i[30:25],
                           instr_i[11:8], 1'b0};
  assign fields_o.imm_u = {instr_i[31:12], 12'b0};  // upper 20 bits
  // J: jal offset, scrambled order
  assign fields_o.imm_j = {{12{sign}}, instr_i[19:12], instr_i[20],
                           instr_i[30:21], 1'b0};

  // csr immediate forms take rs1 as an unsigned value
  assign fields_o.zimm = {{(decoder_pkg::XLEN - decoder_pkg::REG_ADDR_W){1'b0}},
                          instr_i[19:15]};

endmodule

//--- design/decode_result.sv
// result stage with register legality, csr demotion, squash on illegal and the result register
`timescale 1ns/1ns

module decode_result #(
  parameter bit RV32E = 1'b0  // only x0..x15 exist
) (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     req_i,
  input  decoder_pkg::dec_fields_t fields_i,
  input  decoder_pkg::dec_ctrl_t   ctrl_i,
  output logic                     ack_o,
  output decoder_pkg::dec_result_t result_o
);

  localparam int unsigned MSB = decoder_pkg::REG_ADDR_W - 1;

  typedef enum logic {HS_IDLE, HS_BUSY} hs_state_e;

  hs_state_e                state_q;
  logic                     illegal_rv32e;
  decoder_pkg::dec_ctrl_t   ctrl_fix;   // ctrl after legality rules
  decoder_pkg::dec_result_t result_q;

  // register addresses of 16 and above where the operand is really read or written
  assign illegal_rv32e = RV32E &&
    ((fields_i.rs1[MSB] && ctrl_i.op_a_sel == decoder_pkg::OP_A_REG_A) ||
     (fields_i.rs2[MSB] && (ctrl_i.op_b_sel == decoder_pkg::OP_B_REG_B ||
                            ctrl_i.data_we)) ||  // store data comes from rs2
     (fields_i.rd[MSB]  && ctrl_i.rf_we));

  always_comb begin
    ctrl_fix         = ctrl_i;
    ctrl_fix.illegal = ctrl_i.illegal | illegal_rv32e;
    // set/clear from x0 or zimm 0 writes nothing
    if ((ctrl_i.csr_op == decoder_pkg::CSR_OP_SET ||
         ctrl_i.csr_op == decoder_pkg::CSR_OP_CLEAR) && fields_i.rs1 == '0) begin
      ctrl_fix.csr_op = decoder_pkg::CSR_OP_READ;
    end
    if (ctrl_fix.illegal) begin  // no side effects leave the decoder
      ctrl_fix.rf_we      = 1'b0;
      ctrl_fix.data_req   = 1'b0;
      ctrl_fix.data_we    = 1'b0;
      ctrl_fix.mult_en    = 1'b0;
      ctrl_fix.div_en     = 1'b0;
      ctrl_fix.jump       = 1'b0;
      ctrl_fix.branch     = 1'b0;
      ctrl_fix.csr_access = 1'b0;
    end
  end

  ////////////////////////////////////////
  // four-phase handshake
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q  <= HS_IDLE;
      result_q <= '0;
    end else begin
      unique case (state_q)
        HS_IDLE: if (req_i) begin  // capture edge
          result_q.fields <= fields_i;
          result_q.ctrl   <= ctrl_fix;
          state_q         <= HS_BUSY;
        end
        HS_BUSY: if (!req_i) state_q <= HS_IDLE;  // hold until req drops
      endcase
    end
  end

  assign ack_o    = (state_q == HS_BUSY);
  assign result_o = result_q;

endmodule

//--- design/decoder_pkg.sv
// opcode and control encodings plus the decoded record layout for the decoder
package decoder_pkg;

  localparam int unsigned XLEN       = 32;  // instruction and immediate width
  localparam int unsigned REG_ADDR_W = 5;   // x0..x31

  ////////////////////////////////////////
  // encodings
  ////////////////////////////////////////

  // major opcodes kept in this decoder
  typedef enum logic [6:0] {
    OPC_LOAD     = 7'b000_0011,
    OPC_MISC_MEM = 7'b000_1111,
    OPC_OP_IMM   = 7'b001_0011,
    OPC_AUIPC    = 7'b001_0111,
    OPC_STORE    = 7'b010_0011,
    OPC_OP       = 7'b011_0011,
    OPC_LUI      = 7'b011_0111,
    OPC_BRANCH   = 7'b110_0011,
    OPC_JALR     = 7'b110_0111,
    OPC_JAL      = 7'b110_1111,
    OPC_SYSTEM   = 7'b111_0011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB,
    ALU_XOR, ALU_OR, ALU_AND,
    ALU_SRA, ALU_SRL, ALU_SLL,
    ALU_SLT, ALU_SLTU,          // set-less-than
    ALU_EQ, ALU_NE,             // branch compares
    ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {OP_A_REG_A, OP_A_CURRPC, OP_A_IMM} op_a_sel_e;
  typedef enum logic       {OP_B_REG_B, OP_B_IMM} op_b_sel_e;
  typedef enum logic       {IMM_A_ZERO, IMM_A_Z} imm_a_sel_e;  // IMM_A_Z is csr zimm
  typedef enum logic [2:0] {IMM_B_I, IMM_B_S, IMM_B_B, IMM_B_U, IMM_B_J} imm_b_sel_e;

  typedef enum logic [1:0] {RF_WD_EX, RF_WD_LSU, RF_WD_CSR} rf_wd_sel_e;

  // access size in the coding the LSU expects
  typedef enum logic [1:0] {
    MEM_WORD = 2'b00,
    MEM_HALF = 2'b01,
    MEM_BYTE = 2'b10
  } mem_size_e;

  typedef enum logic [1:0] {MD_OP_MULL, MD_OP_MULH, MD_OP_DIV, MD_OP_REM} md_op_e;

  typedef enum logic [1:0] {CSR_OP_READ, CSR_OP_WRITE, CSR_OP_SET, CSR_OP_CLEAR} csr_op_e;

  // csr addresses whose access forces a flush
  typedef enum logic [11:0] {
    CSR_MSTATUS   = 12'h300,
    CSR_DCSR      = 12'h7b0,
    CSR_DPC       = 12'h7b1,
    CSR_DSCRATCH0 = 12'h7b2,
    CSR_DSCRATCH1 = 12'h7b3
  } csr_num_e;

  ////////////////////////////////////////
  // decoded record
  ////////////////////////////////////////

  typedef struct packed {
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       imm_i;
    logic [XLEN-1:0]       imm_s;
    logic [XLEN-1:0]       imm_b;
    logic [XLEN-1:0]       imm_u;
    logic [XLEN-1:0]       imm_j;
    logic [XLEN-1:0]       zimm;   // rs1 field zero extended
  } dec_fields_t;

  typedef struct packed {
    alu_op_e    alu_op;
    op_a_sel_e  op_a_sel;
    op_b_sel_e  op_b_sel;
    imm_a_sel_e imm_a_sel;
    imm_b_sel_e imm_b_sel;
    logic       rf_we;
    rf_wd_sel_e rf_wd_sel;
    logic       data_req;
    logic       data_we;
    mem_size_e  data_size;
    logic       data_sign_ext;
    logic       mult_en;
    logic       div_en;
    md_op_e     md_op;
    logic [1:0] md_signed_mode;   // {op b signed, op a signed}
    logic       csr_access;
    csr_op_e    csr_op;
    logic       csr_status;
    logic       jump;
    logic       branch;
    logic       ecall;
    logic       ebrk;
    logic       mret;
    logic       wfi;
    logic       illegal;
  } dec_ctrl_t;

  typedef struct packed {
    dec_fields_t fields;
    dec_ctrl_t   ctrl;
  } dec_result_t;

endpackage

//--- design/rv_decoder.sv
// RISC-V decoder top: fields, control and result stages behind a req/ack handshake
`timescale 1ns/1ns

module rv_decoder #(
  parameter bit RV32E = 1'b0,  // 16-register base
  parameter bit RV32M = 1'b1   // mul/div decode
) (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         req_i,
  input  logic [decoder_pkg::XLEN-1:0] instr_i,  // held stable while req_i is high
  output logic                         ack_o,
  output decoder_pkg::dec_result_t     result_o
);

  decoder_pkg::dec_fields_t fields;  // combinational, zero latency
  decoder_pkg::dec_ctrl_t   ctrl;

  decode_fields u_fields (
    .instr_i  (instr_i),
    .fields_o (fields)
  );

  decode_ctrl #(.RV32M(RV32M)) u_ctrl (
    .instr_i (instr_i),
    .ctrl_o  (ctrl)
  );

  // only stateful stage
  decode_result #(.RV32E(RV32E)) u_result (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .req_i    (req_i),
    .fields_i (fields),
    .ctrl_i   (ctrl),
    .ack_o    (ack_o),
    .result_o (result_o)
  );

endmodule

//--- rv_decoder.f
+incdir+tests
design/decoder_pkg.sv
design/decode_fields.sv
design/decode_ctrl.sv
design/decode_result.sv
design/rv_decoder.sv
tests/decoder_tb.sv

//--- tests/decoder_ref.svh
// decoder reference model with instruction builders and the expected result record
`ifndef DECODER_REF_SVH
`define DECODER_REF_SVH

////////////////////////////////////////
// instruction builders
////////////////////////////////////////

// r-type slot layout that the other formats reuse
function automatic logic [31:0] make_instr(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3, logic [4:0] rd, logic [6:0] opc);
  return {f7, rs2, rs1, f3, rd, opc};
endfunction

// kind 0 alu, 1 load/store, 2 jump/branch, 3 mul/div, 4 system
function automatic logic [31:0] random_instr(int kind, logic [31:0] r, logic [31:0] s,
                                             bit wide);
  logic [31:0] w;
  logic [2:0]  f3;
  logic [6:0]  f7;
  logic [11:0] code;  // system code or csr address
  f3 = r[14:12];
  case (kind)
    0: begin
      case (s[1:0])
        2'd0: begin
          f7 = (s[2] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;  // sub, sra
          w  = make_instr(f7, r[24:20], r[19:15], f3, r[11:7], decoder_pkg::OPC_OP);
        end
        2'd1: begin
          // shift forms need a clean funct7
          f7 = (f3 == 3'd1) ? 7'h00 : (f3 == 3'd5) ? {1'b0, s[2], 5'b0} : r[31:25];
          w  = make_instr(f7, r[24:20], r[19:15], f3, r[11:7], decoder_pkg::OPC_OP_IMM);
        end
        2'd2:    w = {r[31:7], decoder_pkg::OPC_LUI};
        default: w = {r[31:7], decoder_pkg::OPC_AUIPC};
      endcase
    end
    1: w = make_instr(r[31:25], r[24:20], r[19:15], f3, r[11:7],
                      s[0] ? decoder_pkg::OPC_STORE : decoder_pkg::OPC_LOAD);
    2: begin
      case (s[1:0])
        2'd0: w = {r[31:7], decoder_pkg::OPC_JAL};
        2'd1: w = make_instr(r[31:25], r[24:20], r[19:15], s[2] ? f3 : 3'd0, r[11:7],
                             decoder_pkg::OPC_JALR);
        default: w = make_instr(r[31:25], r[24:20], r[19:15], f3, r[11:7],
                                decoder_pkg::OPC_BRANCH);
      endcase
    end
    3: w = make_instr(7'h01, r[24:20], r[19:15], f3, r[11:7], decoder_pkg::OPC_OP);
    default: begin
      if (!s[2]) begin  // ecall, ebreak, mret, wfi
        case (s[1:0])
          2'd0:    code = 12'h000;
          2'd1:    code = 12'h001;
          2'd2:    code = 12'h302;
          default: code = 12'h105;
        endcase
        w = make_instr(code[11:5], code[4:0], (s[5] & s[4]) ? r[19:15] : 5'd0, 3'd0,
                       (s[7] & s[6]) ? r[11:7] : 5'd0, decoder_pkg::OPC_SYSTEM);
      end else begin
        case (s[1:0])
          2'd0:    code = 12'h300;  // mstatus
          2'd1:    code = 12'h7b0;  // dcsr
          2'd2:    code = 12'h7b2;
          default: code = r[31:20];
        endcase
        f3 = (f3[1:0] == 2'b00) ? 3'b100 : f3;  // stay off the funct3 000 row
        w  = make_instr(code[11:5], code[4:0], s[5] ? 5'd0 : r[19:15], f3, r[11:7],
                        decoder_pkg::OPC_SYSTEM);
      end
    end
  endcase
  if (!wide) begin  // registers x0..x15 only
    w[11] = 1'b0;
    w[19] = 1'b0;
    if (w[6:0] == decoder_pkg::OPC_OP || w[6:0] == decoder_pkg::OPC_BRANCH ||
        w[6:0] == decoder_pkg::OPC_STORE) begin
      w[24] = 1'b0;  // rs2 is a register here
    end
  end
  return w;
endfunction

////////////////////////////////////////
// expected record
////////////////////////////////////////

function automatic decoder_pkg::dec_fields_t expect_fields(logic [31:0] w);
  decoder_pkg::dec_fields_t f;
  f.rs1   = w[19:15];
  f.rs2   = w[24:20];
  f.rd    = w[11:7];
  f.imm_i = 32'($signed(w[31:20]));
  f.imm_s = 32'($signed({w[31:25], w[11:7]}));
  f.imm_b = 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
  f.imm_u = {w[31:12], 12'h000};
  f.imm_j = 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
  f.zimm  = 32'(w[19:15]);  // unsigned
  return f;
endfunction

function automatic decoder_pkg::alu_op_e arith_op(logic [2:0] f3, logic alt);
  case (f3)
    3'd0:    return alt ? decoder_pkg::ALU_SUB : decoder_pkg::ALU_ADD;
    3'd1:    return decoder_pkg::ALU_SLL;
    3'd2:    return decoder_pkg::ALU_SLT;
    3'd3:    return decoder_pkg::ALU_SLTU;
    3'd4:    return decoder_pkg::ALU_XOR;
    3'd5:    return alt ? decoder_pkg::ALU_SRA : decoder_pkg::ALU_SRL;
    3'd6:    return decoder_pkg::ALU_OR;
    default: return decoder_pkg::ALU_AND;
  endcase
endfunction

function automatic decoder_pkg::alu_op_e branch_op(logic [2:0] f3);
  case (f3)
    3'd0:    return decoder_pkg::ALU_EQ;
    3'd1:    return decoder_pkg::ALU_NE;
    3'd4:    return decoder_pkg::ALU_LT;
    3'd5:    return decoder_pkg::ALU_GE;
    3'd6:    return decoder_pkg::ALU_LTU;
    3'd7:    return decoder_pkg::ALU_GEU;
    default: return decoder_pkg::ALU_SLTU;  // idle op when there is no compare
  endcase
endfunction

// control fields before the register legality and squash rules
function automatic decoder_pkg::dec_ctrl_t expect_ctrl(logic [31:0] w);
  decoder_pkg::dec_ctrl_t c;
  logic [2:0]  f3;
  logic [6:0]  f7;
  logic [11:0] imm12;
  f3    = w[14:12];
  f7    = w[31:25];
  imm12 = w[31:20];
  c          = '0;  // idle record
  c.alu_op   = decoder_pkg::ALU_SLTU;
  c.op_a_sel = decoder_pkg::OP_A_IMM;
  c.op_b_sel = decoder_pkg::OP_B_IMM;
  case (w[6:0])
    decoder_pkg::OPC_JAL: begin
      c.jump      = 1'b1;
      c.op_a_sel  = decoder_pkg::OP_A_CURRPC;
      c.imm_b_sel = decoder_pkg::IMM_B_J;
      c.alu_op    = decoder_pkg::ALU_ADD;
    end
    decoder_pkg::OPC_JALR: begin
      c.jump     = 1'b1;
      c.op_a_sel = decoder_pkg::OP_A_REG_A;
      c.alu_op   = decoder_pkg::ALU_ADD;
      c.illegal  = (f3 != 3'd0);
    end
    decoder_pkg::OPC_BRANCH: begin
      c.branch    = 1'b1;
      c.op_a_sel  = decoder_pkg::OP_A_REG_A;
      c.op_b_sel  = decoder_pkg::OP_B_REG_B;
      c.imm_b_sel = decoder_pkg::IMM_B_B;
      c.alu_op    = branch_op(f3);
      c.illegal   = (f3[2:1] == 2'b01);
    end
    decoder_pkg::OPC_LOAD, decoder_pkg::OPC_STORE: begin
      c.data_req  = 1'b1;
      c.op_a_sel  = decoder_pkg::OP_A_REG_A;
      c.alu_op    = decoder_pkg::ALU_ADD;
      c.data_size = (f3[1:0] == 2'b00) ? decoder_pkg::MEM_BYTE :
                    (f3[1:0] == 2'b01) ? decoder_pkg::MEM_HALF : decoder_pkg::MEM_WORD;
      if (w[6:0] == decoder_pkg::OPC_STORE) begin
        c.data_we   = 1'b1;
        c.imm_b_sel = decoder_pkg::IMM_B_S;
        c.illegal   = f3[2] || (f3[1:0] == 2'b11);
      end else begin
        c.rf_we         = 1'b1;
        c.rf_wd_sel     = decoder_pkg::RF_WD_LSU;
        c.data_sign_ext = !f3[2];
        c.illegal       = (f3[1:0] == 2'b11) || (f3 == 3'b110);  // ld, lwu, ldu
      end
    end
    decoder_pkg::OPC_LUI, decoder_pkg::OPC_AUIPC: begin
      c.imm_b_sel = decoder_pkg::IMM_B_U;
      c.alu_op    = decoder_pkg::ALU_ADD;
      c.rf_we     = 1'b1;
      if (w[6:0] == decoder_pkg::OPC_AUIPC) c.op_a_sel = decoder_pkg::OP_A_CURRPC;
    end
    decoder_pkg::OPC_OP_IMM: begin
      c.op_a_sel = decoder_pkg::OP_A_REG_A;
      c.rf_we    = 1'b1;
      c.alu_op   = arith_op(f3, (f3 == 3'd5) && f7[5]);
      c.illegal  = ((f3 == 3'd1) && (f7 != 7'h00)) ||
                   ((f3 == 3'd5) && (f7 != 7'h00) && (f7 != 7'h20));
    end
    decoder_pkg::OPC_OP: begin
      c.op_a_sel = decoder_pkg::OP_A_REG_A;
      c.op_b_sel = decoder_pkg::OP_B_REG_B;
      c.rf_we    = 1'b1;
      if (f7 == 7'h01) begin  // mul/div row
        c.alu_op  = decoder_pkg::ALU_ADD;
        c.mult_en = !f3[2];
        c.div_en  = f3[2];
        c.md_op   = f3[2] ? (f3[1] ? decoder_pkg::MD_OP_REM : decoder_pkg::MD_OP_DIV) :
                    ((f3[1:0] == 2'b00) ? decoder_pkg::MD_OP_MULL : decoder_pkg::MD_OP_MULH);
        c.md_signed_mode = (f3 == 3'd1 || f3 == 3'd4 || f3 == 3'd6) ? 2'b11 :
                           (f3 == 3'd2) ? 2'b01 : 2'b00;  // mulhsu signs only rs1
      end else if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) begin
        c.alu_op = arith_op(f3, f7[5]);
      end else begin
        c.illegal = 1'b1;
      end
    end
    decoder_pkg::OPC_MISC_MEM: begin
      c.op_a_sel = decoder_pkg::OP_A_REG_A;
      c.alu_op   = decoder_pkg::ALU_ADD;
      c.illegal  = (f3 != 3'd0);  // fence.i
    end
    decoder_pkg::OPC_SYSTEM: begin
      if (f3 == 3'd0) begin
        c.op_a_sel = decoder_pkg::OP_A_REG_A;
        c.ecall    = (imm12 == 12'h000);
        c.ebrk     = (imm12 == 12'h001);
        c.mret     = (imm12 == 12'h302);
        c.wfi      = (imm12 == 12'h105);
        c.illegal  = !(c.ecall || c.ebrk || c.mret || c.wfi) ||
                     (w[19:15] != 5'd0) || (w[11:7] != 5'd0);
      end else begin
        c.csr_access = 1'b1;
        c.rf_we      = 1'b1;
        c.rf_wd_sel  = decoder_pkg::RF_WD_CSR;
        c.imm_a_sel  = decoder_pkg::IMM_A_Z;
        c.op_a_sel   = f3[2] ? decoder_pkg::OP_A_IMM : decoder_pkg::OP_A_REG_A;
        c.csr_op     = decoder_pkg::csr_op_e'(f3[1:0]);  // 00 stays read and is illegal
        c.illegal    = (f3[1:0] == 2'b00);
        c.csr_status = !c.illegal &&
                       ((imm12 == 12'h300) || (imm12 >= 12'h7b0 && imm12 <= 12'h7b3));
      end
    end
    default: c.illegal = 1'b1;
  endcase
  return c;
endfunction

function automatic decoder_pkg::dec_result_t expect_result(logic [31:0] w, bit rv32e);
  decoder_pkg::dec_result_t e;
  e.fields = expect_fields(w);
  e.ctrl   = expect_ctrl(w);
  // x16..x31 missing in the 16-register base
  if (rv32e && ((e.fields.rs1[4] && e.ctrl.op_a_sel == decoder_pkg::OP_A_REG_A) ||
                (e.fields.rs2[4] && (e.ctrl.op_b_sel == decoder_pkg::OP_B_REG_B ||
                                     w[6:0] == decoder_pkg::OPC_STORE)) ||
                (e.fields.rd[4] && e.ctrl.rf_we))) begin
    e.ctrl.illegal = 1'b1;
  end
  if ((e.ctrl.csr_op == decoder_pkg::CSR_OP_SET || e.ctrl.csr_op == decoder_pkg::CSR_OP_CLEAR)
      && e.fields.rs1 == 5'd0) begin
    e.ctrl.csr_op = decoder_pkg::CSR_OP_READ;  // nothing to set or clear
  end
  if (e.ctrl.illegal) begin
    e.ctrl.rf_we      = 1'b0;
    e.ctrl.data_req   = 1'b0;
    e.ctrl.data_we    = 1'b0;
    e.ctrl.mult_en    = 1'b0;
    e.ctrl.div_en     = 1'b0;
    e.ctrl.jump       = 1'b0;
    e.ctrl.branch     = 1'b0;
    e.ctrl.csr_access = 1'b0;
  end
  return e;
endfunction

`endif

//--- tests/decoder_tb.sv
// decoder testbench driving random instructions through the req/ack handshake
`timescale 1ns/1ns

module decoder_tb;

  localparam int N_PER_KIND  = 60;
  localparam int N_KINDS     = 6;   // alu, ldst, jump, muldiv, system, rv32e
  localparam int N_INSTR     = N_PER_KIND * N_KINDS;
  localparam int CLK_NS      = 4;
  localparam int WATCHDOG_NS = (N_INSTR * 10 + 50) * CLK_NS;  // at most ~8 cycles each

  logic                         clk_i;
  logic                         reset_i;
  logic                         req_i;
  logic [decoder_pkg::XLEN-1:0] instr_i;
  logic                         ack_o;
  decoder_pkg::dec_result_t     result_o;

  integer seed;
  int     value_errors;
  int     hs_errors;
  string  kind_name [N_KINDS] = '{"alu", "ldst", "jump", "muldiv", "system", "rv32e"};

  `include "decoder_ref.svh"

  rv_decoder #(.RV32E(1'b1), .RV32M(1'b1)) DUT (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .req_i    (req_i),
    .instr_i  (instr_i),
    .ack_o    (ack_o),
    .result_o (result_o)
  );

  initial clk_i = 1'b0;
  always #(CLK_NS / 2) clk_i = ~clk_i;

  ////////////////////////////////////////
  // handshake properties
  ////////////////////////////////////////

  ack_rise: assert property (@(posedge clk_i) disable iff (reset_i)
                             req_i && !ack_o |=> ack_o)
    else begin
      hs_errors++;
      $display("ack_o did not rise one cycle after req_i was seen high, t=%0t", $time);
    end

  ack_hold: assert property (@(posedge clk_i) disable iff (reset_i)
                             req_i && ack_o |=> ack_o && $stable(result_o))
    else begin
      hs_errors++;
      $display("ack_o or result_o changed while req_i was held high, t=%0t", $time);
    end

  ack_fall: assert property (@(posedge clk_i) disable iff (reset_i)
                             !req_i && ack_o |=> !ack_o)
    else begin
      hs_errors++;
      $display("ack_o did not fall after req_i was seen low, t=%0t", $time);
    end

  ack_quiet: assert property (@(posedge clk_i) disable iff (reset_i)
                              !req_i && !ack_o |=> !ack_o)
    else begin
      hs_errors++;
      $display("ack_o rose without a request, t=%0t", $time);
    end

  task automatic check_result(input string name, input logic [31:0] w,
                              input decoder_pkg::dec_result_t exp);
    assert (result_o === exp)
      else begin
        value_errors++;
        $display("ERR %s exp=%h act=%h instr=%h", name, exp, result_o, w);
      end
  endtask

  // one four-phase transfer with a random number of back-pressure cycles
  task automatic send_and_check(input string name, input logic [31:0] w);
    decoder_pkg::dec_result_t exp;
    int hold;
    exp  = expect_result(w, 1'b1);
    hold = $random(seed) & 3;
    @(posedge clk_i);
    instr_i <= w;
    req_i   <= 1'b1;
    @(negedge clk_i);
    while (!ack_o) @(negedge clk_i);
    check_result(name, w, exp);
    repeat (hold) @(posedge clk_i);  // req stays high so the record must hold
    @(posedge clk_i);
    req_i <= 1'b0;
    @(negedge clk_i);
    while (ack_o) @(negedge clk_i);  // next request only after ack low
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    logic [31:0] r;
    logic [31:0] s;
    logic [31:0] w;
    int          kind;
    seed         = 32'hc8a7;
    value_errors = 0;
    hs_errors    = 0;
    reset_i      = 1'b1;
    req_i        = 1'b0;
    instr_i      = '0;
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    reset_state: assert (ack_o === 1'b0 && result_o === '0)
      else begin
        hs_errors++;
        $display("ack_o or result_o not cleared by reset");
      end
    for (int i = 0; i < N_INSTR; i++) begin
      kind = i % N_KINDS;
      r    = $random(seed);
      s    = $random(seed);
      if (kind == 5) begin  // any kind over the full register range
        w = random_instr(int'(s[10:8]) % 5, r, s, 1'b1);
      end else begin
        w = random_instr(kind, r, s, 1'b0);
      end
      send_and_check(kind_name[kind], w);
    end
    repeat (2) @(posedge clk_i);  // let the last properties finish
    $display("errors: value %0d, handshake %0d", value_errors, hs_errors);
    if (value_errors == 0 && hs_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule
